/* source/dcache_bridge_pkg.sv */
// Store/AMO bridge package with widths, opcodes and port structs
`default_nettype none

package dcache_bridge_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int unsigned PADDR_W = 32;
    localparam int unsigned INDEX_W = 12;
    localparam int unsigned TAG_W   = PADDR_W - INDEX_W;
    localparam int unsigned DATA_W  = 64;
    localparam int unsigned BE_W    = DATA_W / 8;
    localparam int unsigned TID_W   = 4;
    localparam int unsigned SID_W   = 2;

    // Reserved transaction id for AMO traffic
    localparam logic [TID_W-1:0] AMO_TID = '1;

    // Access size codes on the core port
    localparam logic [1:0] SIZE_WORD  = 2'b10;
    localparam logic [1:0] SIZE_DWORD = 2'b11;

    // ------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------
    // RISC-V AMO codes as driven by the core
    typedef enum logic [3:0] {
        AMO_LR   = 4'd0,
        AMO_SC   = 4'd1,
        AMO_SWAP = 4'd2,
        AMO_ADD  = 4'd3,
        AMO_AND  = 4'd4,
        AMO_OR   = 4'd5,
        AMO_XOR  = 4'd6,
        AMO_MAX  = 4'd7,
        AMO_MAXU = 4'd8,
        AMO_MIN  = 4'd9,
        AMO_MINU = 4'd10
    } amo_op_e;

    // L1 data cache request opcodes
    typedef enum logic [4:0] {
        CACHE_LOAD            = 5'd0,
        CACHE_STORE           = 5'd1,
        CACHE_AMO_LR          = 5'd2,
        CACHE_AMO_SC          = 5'd3,
        CACHE_AMO_SWAP        = 5'd4,
        CACHE_AMO_ADD         = 5'd5,
        CACHE_AMO_AND         = 5'd6,
        CACHE_AMO_OR          = 5'd7,
        CACHE_AMO_XOR         = 5'd8,
        CACHE_AMO_MAX         = 5'd9,
        CACHE_AMO_MAXU        = 5'd10,
        CACHE_AMO_MIN         = 5'd11,
        CACHE_AMO_MINU        = 5'd12,
        CACHE_FLUSH_ALL       = 5'd13,
        CACHE_FLUSH_INVAL_ALL = 5'd14
    } cache_op_e;

    // ------------------------------------------------------------------
    // Port structs
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [INDEX_W-1:0] addr_offset;
        logic [TAG_W-1:0]   addr_tag;
        logic [DATA_W-1:0]  wdata;
        cache_op_e          op;
        logic [BE_W-1:0]    be;
        logic [1:0]         size;
        logic [SID_W-1:0]   sid;
        logic [TID_W-1:0]   tid;
        logic               need_rsp;
        logic               phys_indexed;
        logic               uncacheable;
    } cache_req_t;

    typedef struct packed {
        logic              rvalid;
        logic [TID_W-1:0]  tid;
        logic [DATA_W-1:0] rdata;
    } cache_rsp_t;

    typedef struct packed {
        logic               preq;
        logic [PADDR_W-1:0] paddr;
        logic [DATA_W-1:0]  wdata;
        logic [BE_W-1:0]    be;
        logic [1:0]         size;
        logic               cacheable;
    } store_req_t;

    typedef struct packed {
        logic               preq;
        logic [PADDR_W-1:0] paddr;
        logic [DATA_W-1:0]  wdata;
        amo_op_e            atop;
        logic [1:0]         size;
        logic               cacheable;
    } amo_req_t;

    typedef struct packed {
        logic              pgnt;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } core_rsp_t;

endpackage

`default_nettype wire

/* source/amo_unit.sv */
// AMO formatter with opcode mapping, single-pending tracking and response lane select
`timescale 1ns/1ps
`default_nettype none

module amo_unit
    import dcache_bridge_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire amo_req_t         amo_req_i,
    input  wire logic [SID_W-1:0] sid_i,
    input  wire logic             amo_xfer_i,
    input  wire cache_rsp_t       cache_rsp_i,
    output cache_req_t            amo_cache_req_o,
    output logic                  amo_busy_o,
    output core_rsp_t             amo_rsp_o
);

    cache_op_e         amo_op;
    logic              amo_is_word;
    logic [DATA_W-1:0] amo_data;
    logic [BE_W-1:0]   amo_be;

    logic              amo_busy_q;
    logic              amo_word_q;
    logic              amo_hi_q;
    logic              amo_rsp_hit;
    logic [31:0]       amo_rsp_word;

    // ------------------------------------------------------------------
    // Request formatting
    // ------------------------------------------------------------------
    always_comb begin
        case (amo_req_i.atop)
            AMO_LR:   amo_op = CACHE_AMO_LR;
            AMO_SC:   amo_op = CACHE_AMO_SC;
            AMO_SWAP: amo_op = CACHE_AMO_SWAP;
            AMO_ADD:  amo_op = CACHE_AMO_ADD;
            AMO_AND:  amo_op = CACHE_AMO_AND;
            AMO_OR:   amo_op = CACHE_AMO_OR;
            AMO_XOR:  amo_op = CACHE_AMO_XOR;
            AMO_MAX:  amo_op = CACHE_AMO_MAX;
            AMO_MAXU: amo_op = CACHE_AMO_MAXU;
            AMO_MIN:  amo_op = CACHE_AMO_MIN;
            AMO_MINU: amo_op = CACHE_AMO_MINU;
            default:  amo_op = CACHE_LOAD;
        endcase
    end

    assign amo_is_word = (amo_req_i.size == SIZE_WORD);

    // Word operands go on both halves, the byte enables pick the lane
    assign amo_data = amo_is_word ? {2{amo_req_i.wdata[31:0]}} : amo_req_i.wdata;
    assign amo_be   = !amo_is_word      ? 8'hff :
                      amo_req_i.paddr[2] ? 8'hf0 : 8'h0f;

    always_comb begin
        amo_cache_req_o = '{
            addr_offset:  amo_req_i.paddr[INDEX_W-1:0],
            addr_tag:     amo_req_i.paddr[PADDR_W-1:INDEX_W],
            wdata:        amo_data,
            op:           amo_op,
            be:           amo_be,
            size:         amo_req_i.size,
            sid:          sid_i,
            tid:          AMO_TID,
            need_rsp:     1'b1,
            phys_indexed: 1'b1,
            uncacheable:  !amo_req_i.cacheable
        };
    end

    // ------------------------------------------------------------------
    // Pending tracking
    // ------------------------------------------------------------------
    assign amo_rsp_hit = cache_rsp_i.rvalid && (cache_rsp_i.tid == AMO_TID) && amo_busy_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            amo_busy_q <= 1'b0;
        end else if (amo_xfer_i) begin
            amo_busy_q <= 1'b1;
        end else if (amo_rsp_hit) begin
            amo_busy_q <= 1'b0;
        end
    end

    // Lane info captured with the request, the core may move on after pgnt
    always_ff @(posedge clk_i) begin
        if (amo_xfer_i) begin
            amo_word_q <= amo_is_word;
            amo_hi_q   <= amo_req_i.paddr[2];
        end
    end

    assign amo_busy_o = amo_busy_q;

    // ------------------------------------------------------------------
    // Response extraction
    // ------------------------------------------------------------------
    assign amo_rsp_word = amo_hi_q ? cache_rsp_i.rdata[63:32] : cache_rsp_i.rdata[31:0];

    always_comb begin
        amo_rsp_o.pgnt   = 1'b0;
        amo_rsp_o.rvalid = amo_rsp_hit;
        amo_rsp_o.rdata  = amo_word_q ? {{32{amo_rsp_word[31]}}, amo_rsp_word}
                                      : cache_rsp_i.rdata;
    end

endmodule

`default_nettype wire

/* source/flush_sequencer.sv */
// Whole-cache flush FSM issuing the flush request and the core acknowledge
`timescale 1ns/1ps
`default_nettype none

module flush_sequencer
    import dcache_bridge_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire logic       flush_i,
    input  wire logic       flush_xfer_i,
    input  wire cache_rsp_t cache_rsp_i,
    output logic            flush_req_o,
    output logic            flush_ack_o
);

    typedef enum logic {
        FLUSH_IDLE,
        FLUSH_PEND
    } flush_state_e;

    flush_state_e state_q;
    flush_state_e state_d;

    always_comb begin
        state_d     = state_q;
        flush_req_o = 1'b0;
        flush_ack_o = 1'b0;

        case (state_q)
            FLUSH_IDLE: begin
                flush_req_o = flush_i;
                if (flush_xfer_i) begin
                    state_d = FLUSH_PEND;
                end
            end
            FLUSH_PEND: begin
                // Flush completion comes back on tid 0
                if (cache_rsp_i.rvalid && (cache_rsp_i.tid == '0)) begin
                    flush_ack_o = 1'b1;
                    state_d     = FLUSH_IDLE;
                end
            end
            default: begin
                state_d = FLUSH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FLUSH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* source/request_mux.sv */
// Cache request builder and priority selector for AMO, store and flush traffic
`timescale 1ns/1ps
`default_nettype none

module request_mux
    import dcache_bridge_pkg::*;
#(
    parameter bit INVAL_ON_FLUSH = 1'b0
) (
    input  wire store_req_t       store_req_i,
    input  wire amo_req_t         amo_req_i,
    input  wire cache_req_t       amo_cache_req_i,
    input  wire logic             amo_busy_i,
    input  wire logic             flush_req_i,
    input  wire logic [SID_W-1:0] sid_i,
    input  wire logic             cache_req_ready_i,
    output logic                  cache_req_valid_o,
    output cache_req_t            cache_req_o,
    output logic                  store_pgnt_o,
    output logic                  amo_pgnt_o,
    output logic                  amo_xfer_o,
    output logic                  flush_xfer_o
);

    localparam cache_op_e FLUSH_OP = INVAL_ON_FLUSH ? CACHE_FLUSH_INVAL_ALL : CACHE_FLUSH_ALL;

    cache_req_t store_cache_req;
    cache_req_t flush_cache_req;

    logic fwd_amo;
    logic fwd_store;
    logic fwd_flush;

    // ------------------------------------------------------------------
    // Request construction
    // ------------------------------------------------------------------
    always_comb begin
        store_cache_req = '{
            addr_offset:  store_req_i.paddr[INDEX_W-1:0],
            addr_tag:     store_req_i.paddr[PADDR_W-1:INDEX_W],
            wdata:        store_req_i.wdata,
            op:           CACHE_STORE,
            be:           store_req_i.be,
            size:         store_req_i.size,
            sid:          sid_i,
            tid:          '0,
            need_rsp:     1'b0,
            phys_indexed: 1'b1,
            uncacheable:  !store_req_i.cacheable
        };
    end

    // Flush carries no address, completion comes back on tid 0
    always_comb begin
        flush_cache_req = '{
            addr_offset:  '0,
            addr_tag:     '0,
            wdata:        '0,
            op:           FLUSH_OP,
            be:           '0,
            size:         '0,
            sid:          sid_i,
            tid:          '0,
            need_rsp:     1'b1,
            phys_indexed: 1'b0,
            uncacheable:  1'b0
        };
    end

    // ------------------------------------------------------------------
    // Selection
    // ------------------------------------------------------------------
    // A second AMO waits here until the first one has its response
    assign fwd_amo   = amo_req_i.preq && !amo_busy_i;
    assign fwd_store = !fwd_amo && store_req_i.preq;
    assign fwd_flush = !fwd_amo && !store_req_i.preq && flush_req_i;

    assign cache_req_valid_o = fwd_amo || fwd_store || fwd_flush;

    always_comb begin
        if (fwd_amo) begin
            cache_req_o = amo_cache_req_i;
        end else if (fwd_store) begin
            cache_req_o = store_cache_req;
        end else begin
            cache_req_o = flush_cache_req;
        end
    end

    // Grants only on an actual transfer
    assign amo_pgnt_o   = fwd_amo && cache_req_ready_i;
    assign store_pgnt_o = fwd_store && cache_req_ready_i;
    assign amo_xfer_o   = amo_pgnt_o;
    assign flush_xfer_o = fwd_flush && cache_req_ready_i;

endmodule

`default_nettype wire

/* source/store_amo_bridge.sv */
// Store and AMO port bridge from the core to the L1 data cache request port
`timescale 1ns/1ps
`default_nettype none

module store_amo_bridge
    import dcache_bridge_pkg::*;
#(
    parameter bit INVAL_ON_FLUSH = 1'b0
) (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire logic [SID_W-1:0] sid_i,
    input  wire store_req_t       store_req_i,
    output core_rsp_t             store_rsp_o,
    input  wire amo_req_t         amo_req_i,
    output core_rsp_t             amo_rsp_o,
    input  wire logic             flush_i,
    output logic                  flush_ack_o,
    output logic                  cache_req_valid_o,
    input  wire logic             cache_req_ready_i,
    output cache_req_t            cache_req_o,
    input  wire cache_rsp_t       cache_rsp_i
);

    cache_req_t amo_cache_req;
    core_rsp_t  amo_unit_rsp;
    logic       amo_busy;
    logic       amo_xfer;
    logic       amo_pgnt;
    logic       store_pgnt;
    logic       flush_req;
    logic       flush_xfer;

    amo_unit u_amo_unit (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .amo_req_i       (amo_req_i),
        .sid_i           (sid_i),
        .amo_xfer_i      (amo_xfer),
        .cache_rsp_i     (cache_rsp_i),
        .amo_cache_req_o (amo_cache_req),
        .amo_busy_o      (amo_busy),
        .amo_rsp_o       (amo_unit_rsp)
    );

    flush_sequencer u_flush_sequencer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .flush_xfer_i (flush_xfer),
        .cache_rsp_i  (cache_rsp_i),
        .flush_req_o  (flush_req),
        .flush_ack_o  (flush_ack_o)
    );

    request_mux #(
        .INVAL_ON_FLUSH (INVAL_ON_FLUSH)
    ) u_request_mux (
        .store_req_i       (store_req_i),
        .amo_req_i         (amo_req_i),
        .amo_cache_req_i   (amo_cache_req),
        .amo_busy_i        (amo_busy),
        .flush_req_i       (flush_req),
        .sid_i             (sid_i),
        .cache_req_ready_i (cache_req_ready_i),
        .cache_req_valid_o (cache_req_valid_o),
        .cache_req_o       (cache_req_o),
        .store_pgnt_o      (store_pgnt),
        .amo_pgnt_o        (amo_pgnt),
        .amo_xfer_o        (amo_xfer),
        .flush_xfer_o      (flush_xfer)
    );

    // Stores need no response, only the grant goes back
    assign store_rsp_o = '{pgnt: store_pgnt, rvalid: 1'b0, rdata: '0};
    assign amo_rsp_o   = '{pgnt: amo_pgnt, rvalid: amo_unit_rsp.rvalid, rdata: amo_unit_rsp.rdata};

endmodule

`default_nettype wire

/* verif/store_amo_bridge_sva.sv */
// Protocol assertions for the store/AMO bridge ports
`timescale 1ns/1ps
`default_nettype none

module store_amo_bridge_sva
    import dcache_bridge_pkg::*;
(
    input wire logic       clk_i,
    input wire logic       rst_ni,
    input wire store_req_t store_req_i,
    input wire amo_req_t   amo_req_i,
    input wire logic       flush_i,
    input wire logic       flush_ack_o,
    input wire logic       cache_req_valid_o,
    input wire logic       cache_req_ready_i,
    input wire cache_req_t cache_req_o
);

    // Core side offers one kind of request at a time
    one_core_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({store_req_i.preq, amo_req_i.preq, flush_i}))
        else $error("more than one core request at once");

    // Stalled request holds still
    stable_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cache_req_valid_o && !cache_req_ready_i |=> $stable(cache_req_o))
        else $error("cache request changed while stalled");

    // Flush acknowledge is a single pulse
    flush_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_ack_o |=> !flush_ack_o)
        else $error("flush acknowledge held for two cycles");

endmodule

bind store_amo_bridge store_amo_bridge_sva u_store_amo_bridge_sva (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .store_req_i       (store_req_i),
    .amo_req_i         (amo_req_i),
    .flush_i           (flush_i),
    .flush_ack_o       (flush_ack_o),
    .cache_req_valid_o (cache_req_valid_o),
    .cache_req_ready_i (cache_req_ready_i),
    .cache_req_o       (cache_req_o)
);

`default_nettype wire

/* verif/tb_store_amo_bridge.sv */
// Testbench for the store/AMO bridge with a cache model and a stimulus table
`timescale 1ns/1ps
`default_nettype none

module tb_store_amo_bridge
    import dcache_bridge_pkg::*;
;

    localparam logic [1:0] KIND_STORE = 2'd0;
    localparam logic [1:0] KIND_AMO   = 2'd1;
    localparam logic [1:0] KIND_FLUSH = 2'd2;

    typedef struct packed {
        logic [1:0]         kind;
        amo_op_e            atop;
        logic [PADDR_W-1:0] paddr;
        logic [DATA_W-1:0]  wdata;
        logic [1:0]         size;
        logic               cacheable;
        logic [BE_W-1:0]    be;
        logic [DATA_W-1:0]  rsp_data;
        cache_op_e          exp_op;
        logic [DATA_W-1:0]  exp_wdata;
        logic [BE_W-1:0]    exp_be;
        logic [DATA_W-1:0]  exp_rdata;
    } test_vec_t;

    logic             clk_i = 1'b0;
    logic             rst_ni;
    logic [SID_W-1:0] sid;
    store_req_t       store_req;
    amo_req_t         amo_req;
    logic             flush;
    logic             cache_ready;
    cache_rsp_t       cache_rsp;
    core_rsp_t        store_rsp;
    core_rsp_t        amo_rsp;
    logic             flush_ack;
    logic             cache_valid;
    cache_req_t       cache_req;

    test_vec_t vecs[$];
    int        errors = 0;
    integer    seed = 32'hde1c976c;
    logic      table_ready = 1'b0;

    store_amo_bridge uut (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .sid_i             (sid),
        .store_req_i       (store_req),
        .store_rsp_o       (store_rsp),
        .amo_req_i         (amo_req),
        .amo_rsp_o         (amo_rsp),
        .flush_i           (flush),
        .flush_ack_o       (flush_ack),
        .cache_req_valid_o (cache_valid),
        .cache_req_ready_i (cache_ready),
        .cache_req_o       (cache_req),
        .cache_rsp_i       (cache_rsp)
    );

    always #2 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic check_val(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
        assert (exp_val === act_val) else begin
            $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic add_vec(input logic [1:0] kind, input amo_op_e atop,
                           input logic [31:0] paddr, input logic [63:0] wdata,
                           input logic [1:0] size, input logic cacheable,
                           input logic [7:0] be, input logic [63:0] rsp_data,
                           input cache_op_e exp_op, input logic [63:0] exp_wdata,
                           input logic [7:0] exp_be, input logic [63:0] exp_rdata);
        vecs.push_back('{kind, atop, paddr, wdata, size, cacheable, be, rsp_data,
                         exp_op, exp_wdata, exp_be, exp_rdata});
    endtask

    // Fields of the request seen at the transfer
    // Flush entries carry zero address, data, be and size
    task automatic check_req(input test_vec_t v);
        logic [TID_W-1:0] exp_tid;
        exp_tid = (v.kind == KIND_AMO) ? AMO_TID : '0;
        check_val("cache_req_o.op", 64'(v.exp_op), 64'(cache_req.op));
        check_val("cache_req_o.tid", 64'(exp_tid), 64'(cache_req.tid));
        check_val("cache_req_o.sid", 64'(sid), 64'(cache_req.sid));
        check_val("cache_req_o.need_rsp", 64'(v.kind != KIND_STORE), 64'(cache_req.need_rsp));
        check_val("cache_req_o.phys_indexed", 64'(v.kind != KIND_FLUSH),
                  64'(cache_req.phys_indexed));
        check_val("cache_req_o.addr_offset", 64'(v.paddr[INDEX_W-1:0]),
                  64'(cache_req.addr_offset));
        check_val("cache_req_o.addr_tag", 64'(v.paddr[PADDR_W-1:INDEX_W]),
                  64'(cache_req.addr_tag));
        check_val("cache_req_o.wdata", v.exp_wdata, cache_req.wdata);
        check_val("cache_req_o.be", 64'(v.exp_be), 64'(cache_req.be));
        check_val("cache_req_o.size", 64'(v.size), 64'(cache_req.size));
        check_val("cache_req_o.uncacheable", 64'((v.kind != KIND_FLUSH) && !v.cacheable),
                  64'(cache_req.uncacheable));
        check_val("store_rsp_o.pgnt", 64'(v.kind == KIND_STORE), 64'(store_rsp.pgnt));
        check_val("amo_rsp_o.pgnt", 64'(v.kind == KIND_AMO), 64'(amo_rsp.pgnt));
        check_val("store_rsp_o.rvalid", 64'd0, 64'(store_rsp.rvalid));
    endtask

    // Random ready until the request transfers, checking stalls on the way
    task automatic wait_xfer(input test_vec_t v);
        logic       stalled;
        cache_req_t held;
        stalled = 1'b0;
        forever begin
            @(posedge clk_i);
            cache_ready <= 1'($random(seed));
            @(negedge clk_i);
            if (stalled && cache_valid) begin
                check_val("cache_req_o stable", 64'd1, 64'(cache_req === held));
            end
            if (cache_valid && cache_ready) begin
                check_req(v);
                break;
            end
            if (cache_valid) begin
                check_val("pgnt while stalled", 64'd0, 64'(store_rsp.pgnt | amo_rsp.pgnt));
                held    = cache_req;
                stalled = 1'b1;
            end
        end
    endtask

    task automatic run_amo(input test_vec_t v);
        for (int pass = 0; pass < 2; pass++) begin
            wait_xfer(v);
            @(posedge clk_i);
            cache_ready <= 1'b0;
            // First pass keeps the AMO offered, it has to wait for the response
            // Second pass the core moves on and the address goes away
            if (pass == 1) begin
                amo_req <= '0;
            end
            repeat (2) begin
                @(negedge clk_i);
                check_val("amo_rsp_o.rvalid", 64'd0, 64'(amo_rsp.rvalid));
                if (pass == 0) begin
                    check_val("cache_req_valid_o", 64'd0, 64'(cache_valid));
                    check_val("amo_rsp_o.pgnt", 64'd0, 64'(amo_rsp.pgnt));
                end
                @(posedge clk_i);
            end
            cache_rsp <= '{rvalid: 1'b1, tid: AMO_TID, rdata: v.rsp_data};
            @(negedge clk_i);
            check_val("amo_rsp_o.rvalid", 64'd1, 64'(amo_rsp.rvalid));
            check_val("amo_rsp_o.rdata", v.exp_rdata, amo_rsp.rdata);
            if (pass == 0) begin
                check_val("cache_req_valid_o", 64'd0, 64'(cache_valid));
            end
            @(posedge clk_i);
            cache_rsp.rvalid <= 1'b0;
            if (pass == 0) begin
                @(negedge clk_i);
                check_val("cache_req_valid_o after rsp", 64'd1, 64'(cache_valid));
            end
        end
    endtask

    task automatic run_flush(input test_vec_t v);
        wait_xfer(v);
        @(posedge clk_i);
        cache_ready <= 1'b0;
        repeat (2) begin
            @(negedge clk_i);
            check_val("flush_ack_o", 64'd0, 64'(flush_ack));
            @(posedge clk_i);
        end
        cache_rsp <= '{rvalid: 1'b1, tid: '0, rdata: '0};
        @(negedge clk_i);
        check_val("flush_ack_o", 64'd1, 64'(flush_ack));
        @(posedge clk_i);
        flush            <= 1'b0;
        cache_rsp.rvalid <= 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------------------
    initial begin
        wait (table_ready);
        #(vecs.size() * 40 * 4);
        $display("Timeout: the run did not finish in time, %0d errors so far", errors);
        $display("sim failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        rst_ni      = 1'b0;
        sid         = 2'b01;
        store_req   = '0;
        amo_req     = '0;
        flush       = 1'b0;
        cache_ready = 1'b0;
        cache_rsp   = '0;

        add_vec(KIND_STORE, AMO_LR, 32'h8000_1238, 64'h1122_3344_5566_7788, SIZE_WORD, 1'b1,
                8'hf0, 64'h0, CACHE_STORE, 64'h1122_3344_5566_7788, 8'hf0, 64'h0);
        add_vec(KIND_AMO, AMO_ADD, 32'h8000_2000, 64'haaaa_aaaa_1234_5678, SIZE_WORD, 1'b1,
                8'h0, 64'h0000_0000_8000_0001, CACHE_AMO_ADD, 64'h1234_5678_1234_5678,
                8'h0f, 64'hffff_ffff_8000_0001);
        add_vec(KIND_AMO, AMO_SWAP, 32'h8000_2004, 64'h0000_0000_cafe_f00d, SIZE_WORD, 1'b1,
                8'h0, 64'h7654_3210_0000_0000, CACHE_AMO_SWAP, 64'hcafe_f00d_cafe_f00d,
                8'hf0, 64'h0000_0000_7654_3210);
        add_vec(KIND_AMO, AMO_MAXU, 32'h8000_3008, 64'hdead_beef_0123_4567, SIZE_DWORD, 1'b0,
                8'h0, 64'h8877_6655_4433_2211, CACHE_AMO_MAXU, 64'hdead_beef_0123_4567,
                8'hff, 64'h8877_6655_4433_2211);
        add_vec(KIND_FLUSH, AMO_LR, 32'h0, 64'h0, 2'b00, 1'b0,
                8'h0, 64'h0, CACHE_FLUSH_ALL, 64'h0, 8'h0, 64'h0);
        add_vec(KIND_STORE, AMO_LR, 32'h0000_0ff8, 64'h0bad_f00d_1234_abcd, SIZE_DWORD, 1'b0,
                8'hff, 64'h0, CACHE_STORE, 64'h0bad_f00d_1234_abcd, 8'hff, 64'h0);
        add_vec(KIND_AMO, AMO_LR, 32'h8000_4ffc, 64'h0, SIZE_WORD, 1'b1,
                8'h0, 64'h9000_0000_0000_0001, CACHE_AMO_LR, 64'h0, 8'hf0, 64'hffff_ffff_9000_0000);
        add_vec(KIND_AMO, AMO_SC, 32'h8000_4ff8, 64'h0000_0000_0000_0001, SIZE_WORD, 1'b1,
                8'h0, 64'h0, CACHE_AMO_SC, 64'h0000_0001_0000_0001, 8'h0f, 64'h0);
        add_vec(KIND_AMO, AMO_AND, 32'h8000_5010, 64'hf0f0_f0f0_0f0f_0f0f, SIZE_DWORD, 1'b1,
                8'h0, 64'h0123_4567_89ab_cdef, CACHE_AMO_AND, 64'hf0f0_f0f0_0f0f_0f0f,
                8'hff, 64'h0123_4567_89ab_cdef);
        add_vec(KIND_AMO, AMO_OR, 32'h8000_5020, 64'h5555_5555_0000_00ff, SIZE_WORD, 1'b1,
                8'h0, 64'h1111_1111_7fff_ffff, CACHE_AMO_OR, 64'h0000_00ff_0000_00ff,
                8'h0f, 64'h0000_0000_7fff_ffff);
        add_vec(KIND_AMO, AMO_XOR, 32'h8000_5024, 64'h0000_0000_8000_0000, SIZE_WORD, 1'b0,
                8'h0, 64'hffff_fffe_0000_0000, CACHE_AMO_XOR, 64'h8000_0000_8000_0000,
                8'hf0, 64'hffff_ffff_ffff_fffe);
        add_vec(KIND_AMO, AMO_MAX, 32'h8000_5028, 64'h7fff_ffff_ffff_ffff, SIZE_DWORD, 1'b1,
                8'h0, 64'h8000_0000_0000_0000, CACHE_AMO_MAX, 64'h7fff_ffff_ffff_ffff,
                8'hff, 64'h8000_0000_0000_0000);
        add_vec(KIND_AMO, AMO_MIN, 32'h8000_5030, 64'h0000_0000_ffff_ffff, SIZE_WORD, 1'b1,
                8'h0, 64'h0000_0001_ffff_fffe, CACHE_AMO_MIN, 64'hffff_ffff_ffff_ffff,
                8'h0f, 64'hffff_ffff_ffff_fffe);
        add_vec(KIND_AMO, AMO_MINU, 32'h8000_5034, 64'h0000_0000_0000_0002, SIZE_WORD, 1'b1,
                8'h0, 64'h0000_0003_0000_0000, CACHE_AMO_MINU, 64'h0000_0002_0000_0002,
                8'hf0, 64'h0000_0000_0000_0003);
        add_vec(KIND_FLUSH, AMO_LR, 32'h0, 64'h0, 2'b00, 1'b0,
                8'h0, 64'h0, CACHE_FLUSH_ALL, 64'h0, 8'h0, 64'h0);
        table_ready = 1'b1;

        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_val("cache_req_valid_o after reset", 64'd0, 64'(cache_valid));
        check_val("flush_ack_o after reset", 64'd0, 64'(flush_ack));

        foreach (vecs[i]) begin
            @(posedge clk_i);
            case (vecs[i].kind)
                KIND_STORE: begin
                    store_req <= '{1'b1, vecs[i].paddr, vecs[i].wdata, vecs[i].be,
                                   vecs[i].size, vecs[i].cacheable};
                    wait_xfer(vecs[i]);
                    @(posedge clk_i);
                    store_req.preq <= 1'b0;
                    cache_ready    <= 1'b0;
                    @(negedge clk_i);
                    check_val("store_rsp_o.pgnt after xfer", 64'd0, 64'(store_rsp.pgnt));
                end
                KIND_AMO: begin
                    amo_req <= '{1'b1, vecs[i].paddr, vecs[i].wdata, vecs[i].atop,
                                 vecs[i].size, vecs[i].cacheable};
                    run_amo(vecs[i]);
                end
                default: begin
                    flush <= 1'b1;
                    run_flush(vecs[i]);
                end
            endcase
        end

        repeat (2) @(posedge clk_i);
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/dcache_bridge_pkg.sv
source/amo_unit.sv
source/flush_sequencer.sv
source/request_mux.sv
source/store_amo_bridge.sv
verif/store_amo_bridge_sva.sv
verif/tb_store_amo_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the store/AMO bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module tb_store_amo_bridge -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
